// File: kp_pkg.sv
package kp_pkg;

    localparam int img_w     = 16;                  // pixels per row
    localparam int img_h     = 16;                  // rows per image
    localparam int pix_bits  = 8;
    localparam int dog_bits  = pix_bits + 1;        // signed pixel minus blur
    localparam int vsum_bits = pix_bits + 2;        // vertical 1-2-1 sum, weight 4
    localparam int hsum_bits = pix_bits + 4;        // full 3x3 sum, weight 16
    localparam int step_bits = $clog2(img_h + 3);   // blur runs img_h+3 steps

    typedef logic [pix_bits-1:0]        pixel_t;
    typedef logic signed [dog_bits-1:0] dog_t;      // also the line buffer element
    typedef pixel_t [img_w-1:0]         row_t;      // one memory word
    typedef dog_t [img_w-1:0]           dog_row_t;
    typedef logic [$clog2(img_h)-1:0]   row_addr_t;
    typedef logic [$clog2(img_w)-1:0]   col_addr_t;
    typedef logic [dog_bits-1:0]        thresh_t;   // unsigned magnitude
    typedef logic [7:0]                 count_t;    // up to 14*14 interior hits
    typedef logic [step_bits-1:0]       step_t;

    typedef struct packed {
        row_addr_t row;
        col_addr_t col;
        dog_t      value;                           // difference at the extremum
    } keypoint_t;

    typedef struct packed {
        dog_row_t top;
        dog_row_t mid;                              // row under test / being blurred
        dog_row_t bottom;                           // newest row
    } window_t;

    typedef enum logic [1:0] {
        ph_idle,
        ph_blur,
        ph_detect,
        ph_finished                                 // holds until the next start
    } phase_t;

    // scan sequencing, see kp_scan_counter
    localparam step_t     blur_last  = step_t'(img_h + 2);     // final blur step
    localparam step_t     tail_step  = step_t'(img_h + 1);     // bottom pad / stream drain
    localparam step_t     scan_first = step_t'(3);             // first interior mid row
    localparam step_t     scan_last  = step_t'(img_h);         // mid row img_h-2
    localparam col_addr_t col_first  = col_addr_t'(1);
    localparam col_addr_t col_last   = col_addr_t'(img_w - 2);
    localparam row_addr_t blur_lag   = row_addr_t'(3);         // blur write trails read
    localparam row_addr_t mid_lag    = row_addr_t'(2);         // mid row trails fetch

endpackage

// File: kp_row_mem.sv
`timescale 1ns/100ps

module kp_row_mem import kp_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  row_addr_t addr,
    input  row_t      din,
    output row_t      dout
);

    row_t mem [img_h];                      // one image row per word

    // single port, read data one cycle after the address
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;               // whole row at once
        end
        dout <= mem[addr];                  // old contents on a write cycle
    end

endmodule

// File: kp_line_buffer.sv
`timescale 1ns/100ps

module kp_line_buffer import kp_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     shift,
    input  logic     fill_zero,
    input  dog_row_t row_in,
    output window_t  window
);

    dog_row_t entry;                            // row entering at the bottom

    assign entry = fill_zero ? '0 : row_in;     // zero row pads above/below the image

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            window <= '0;
        end else if (shift) begin
            window.top    <= window.mid;        // oldest row drops out
            window.mid    <= window.bottom;
            window.bottom <= entry;
        end
    end

endmodule

// File: kp_gauss_row.sv
`timescale 1ns/100ps

module kp_gauss_row import kp_pkg::*; (
    input  window_t window,
    output row_t    blur_row
);

    logic [vsum_bits-1:0] vsum [img_w+2];       // column sums, index shifted by one
    logic [hsum_bits-1:0] hsum [img_w];

    always_comb begin
        vsum[0]       = '0;                     // left of column 0
        vsum[img_w+1] = '0;                     // right of the last column
        // buffer holds zero-extended pixels here, low byte is the pixel
        for (int i = 0; i < img_w; i++) begin
            vsum[i+1] = vsum_bits'(window.top[i][pix_bits-1:0])
                      + (vsum_bits'(window.mid[i][pix_bits-1:0]) << 1)
                      + vsum_bits'(window.bottom[i][pix_bits-1:0]);
        end
        for (int i = 0; i < img_w; i++) begin
            hsum[i] = hsum_bits'(vsum[i])
                    + (hsum_bits'(vsum[i+1]) << 1)
                    + hsum_bits'(vsum[i+2]);
            blur_row[i] = hsum[i][hsum_bits-1 -: pix_bits];    // /16, truncated
        end
    end

endmodule

// File: kp_dog_extrema.sv
`timescale 1ns/100ps

module kp_dog_extrema import kp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  row_t      img_row,
    input  row_t      blur_row,
    output dog_row_t  dog_row,
    input  window_t   window,
    input  col_addr_t col,
    input  row_addr_t row,
    input  logic      scan_active,
    input  logic      filter_on,
    input  thresh_t   filter_threshold,
    output logic      kp_valid,
    input  logic      kp_ready,
    output keypoint_t kp_data,
    output logic      stall
);

    dog_t    center;                            // mid row, scanned column
    dog_t    nbr [8];                           // 3x3 ring around it
    thresh_t mag;                               // |center|
    logic    is_max;
    logic    is_min;
    logic    hit;

    // difference row, pixel minus blurred pixel
    always_comb begin
        for (int i = 0; i < img_w; i++) begin
            dog_row[i] = dog_t'({1'b0, img_row[i]}) - dog_t'({1'b0, blur_row[i]});
        end
    end

    always_comb begin
        center = window.mid[col];
        nbr[0] = window.top[col - 1'b1];
        nbr[1] = window.top[col];
        nbr[2] = window.top[col + 1'b1];
        nbr[3] = window.mid[col - 1'b1];
        nbr[4] = window.mid[col + 1'b1];
        nbr[5] = window.bottom[col - 1'b1];
        nbr[6] = window.bottom[col];
        nbr[7] = window.bottom[col + 1'b1];
        is_max = 1'b1;
        is_min = 1'b1;
        for (int k = 0; k < 8; k++) begin
            is_max = is_max & (center > nbr[k]);    // strict, ties are no hit
            is_min = is_min & (center < nbr[k]);
        end
        mag = center[dog_bits-1] ? thresh_t'(-center) : thresh_t'(center);
        hit = scan_active & (is_max | is_min)
            & (~filter_on | (mag > filter_threshold));
    end

    assign stall = kp_valid & ~kp_ready;        // slot full, scan must wait

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kp_valid <= 1'b0;
        end else if (!stall) begin
            kp_valid <= hit;                    // empty or draining this edge
        end
    end

    always_ff @(posedge clk) begin
        if (!stall && hit) begin
            kp_data.row   <= row;
            kp_data.col   <= col;
            kp_data.value <= center;            // held while stalled
        end
    end

endmodule

// File: kp_scan_counter.sv
`timescale 1ns/100ps

module kp_scan_counter import kp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  phase_t    phase,
    input  logic      stall,
    output row_addr_t row,
    output col_addr_t col,
    output logic      shift,
    output logic      fill_zero,
    output logic      blur_we,
    output logic      scan_active,
    output logic      phase_last
);

    step_t     step_q;                          // blur cycle or detect row step
    logic      fetch_q;                         // detect address cycle
    col_addr_t col_q;
    logic      in_blur;
    logic      in_detect;
    logic      scan_row;                        // mid row is interior
    logic      step_done;                       // last column of a row step taken

    assign in_blur   = (phase == ph_blur);
    assign in_detect = (phase == ph_detect);
    assign scan_row  = (step_q >= scan_first) && (step_q <= scan_last);
    assign step_done = in_detect && !fetch_q && !stall && (col_q == col_last);

    assign row = row_addr_t'(step_q);           // memory read address
    assign col = col_q;

    // blur: zero row, rows 0..img_h-1, zero row, one step behind the read
    // detect: row step_q shifts in at the end of its step
    assign shift       = in_blur ? (step_q <= tail_step)
                                 : (step_done && (step_q < step_t'(img_h)));
    assign fill_zero   = in_blur && ((step_q == '0) || (step_q == tail_step));
    assign blur_we     = in_blur && (step_q >= step_t'(blur_lag));
    assign scan_active = in_detect && !fetch_q && scan_row;
    assign phase_last  = in_blur ? (step_q == blur_last)
                                 : (step_done && (step_q == tail_step));  // stream drained

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step_q  <= '0;
            fetch_q <= 1'b1;
            col_q   <= '0;
        end else begin
            case (phase)
                ph_blur: begin
                    step_q  <= phase_last ? '0 : step_q + 1'b1;     // one row per cycle
                    fetch_q <= 1'b1;                                // detect opens on a fetch
                end
                ph_detect: begin
                    if (fetch_q) begin
                        fetch_q <= 1'b0;
                        col_q   <= scan_row ? col_first : col_last; // edge rows skip the scan
                    end else if (!stall) begin
                        if (col_q == col_last) begin
                            step_q  <= phase_last ? '0 : step_q + 1'b1;
                            fetch_q <= 1'b1;
                        end else begin
                            col_q <= col_q + 1'b1;
                        end
                    end
                end
                default: begin                                      // idle, finished
                    step_q  <= '0;
                    fetch_q <= 1'b1;
                    col_q   <= '0;
                end
            endcase
        end
    end

endmodule

// File: kp_phase_fsm.sv
`timescale 1ns/100ps

module kp_phase_fsm import kp_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  logic   phase_last,
    input  logic   kp_fire,
    output phase_t phase,
    output logic   busy,
    output logic   done,
    output count_t kp_count
);

    phase_t phase_d;
    logic   start_ok;                           // start taken only when not busy

    assign start_ok = start && ((phase == ph_idle) || (phase == ph_finished));
    assign busy     = (phase == ph_blur) || (phase == ph_detect);
    assign done     = (phase == ph_finished);

    always_comb begin
        phase_d = phase;
        case (phase)
            ph_idle: begin
                if (start_ok) phase_d = ph_blur;
            end
            ph_blur: begin
                if (phase_last) phase_d = ph_detect;    // blur memory complete
            end
            ph_detect: begin
                if (phase_last) phase_d = ph_finished;  // last keypoint gone
            end
            ph_finished: begin
                if (start_ok) phase_d = ph_blur;        // fresh run, new image
            end
            default: phase_d = ph_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= ph_idle;
        end else begin
            phase <= phase_d;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kp_count <= '0;
        end else if (start_ok) begin
            kp_count <= '0;                     // restart count per run
        end else if (kp_fire) begin
            kp_count <= kp_count + 1'b1;
        end
    end

endmodule

// File: kp_core.sv
`timescale 1ns/100ps

module kp_core import kp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      img_we,
    input  row_addr_t img_addr,
    input  row_t      img_data,
    input  logic      start,
    input  logic      filter_on,
    input  thresh_t   filter_threshold,
    input  logic      kp_ready,
    output logic      kp_valid,
    output keypoint_t kp_data,
    output count_t    kp_count,
    output logic      busy,
    output logic      done
);

    phase_t    phase;
    row_addr_t scan_row;                        // read row from the counter
    col_addr_t scan_col;
    row_addr_t kp_row;                          // mid row of the window
    logic      shift;
    logic      fill_zero;
    logic      blur_we;
    logic      scan_active;
    logic      phase_last;
    logic      stall;
    logic      kp_fire;
    row_addr_t img_mem_addr;
    row_addr_t blur_addr;
    row_t      img_dout;
    row_t      blur_dout;
    row_t      blur_row;
    dog_row_t  dog_row;
    dog_row_t  lb_in;
    window_t   window;

    assign kp_fire = kp_valid & kp_ready;
    assign kp_row  = scan_row - mid_lag;

    // address and buffer-input routing by phase
    always_comb begin
        lb_in = '0;
        case (phase)
            ph_blur: begin
                img_mem_addr = scan_row;
                blur_addr    = scan_row - blur_lag;     // write trails the read
                for (int i = 0; i < img_w; i++) begin
                    lb_in[i] = dog_t'({1'b0, img_dout[i]});  // zero-extended pixel
                end
            end
            ph_detect: begin
                img_mem_addr = scan_row;
                blur_addr    = scan_row;                // both rows in step
                lb_in        = dog_row;
            end
            default: begin
                img_mem_addr = img_addr;                // host load
                blur_addr    = '0;
            end
        endcase
    end

    kp_row_mem img_mem (
        .clk  (clk),
        .we   (img_we & ~busy),                 // host writes only when idle
        .addr (img_mem_addr),
        .din  (img_data),
        .dout (img_dout)
    );

    kp_row_mem blur_mem (
        .clk  (clk),
        .we   (blur_we),
        .addr (blur_addr),
        .din  (blur_row),
        .dout (blur_dout)
    );

    kp_line_buffer u_line_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .shift     (shift),
        .fill_zero (fill_zero),
        .row_in    (lb_in),
        .window    (window)
    );

    kp_gauss_row u_gauss_row (
        .window   (window),
        .blur_row (blur_row)
    );

    kp_dog_extrema u_dog_extrema (
        .clk              (clk),
        .rst_n            (rst_n),
        .img_row          (img_dout),
        .blur_row         (blur_dout),
        .dog_row          (dog_row),
        .window           (window),
        .col              (scan_col),
        .row              (kp_row),
        .scan_active      (scan_active),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .kp_valid         (kp_valid),
        .kp_ready         (kp_ready),
        .kp_data          (kp_data),
        .stall            (stall)
    );

    kp_scan_counter u_scan_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase       (phase),
        .stall       (stall),
        .row         (scan_row),
        .col         (scan_col),
        .shift       (shift),
        .fill_zero   (fill_zero),
        .blur_we     (blur_we),
        .scan_active (scan_active),
        .phase_last  (phase_last)
    );

    kp_phase_fsm u_phase_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .phase_last (phase_last),
        .kp_fire    (kp_fire),
        .phase      (phase),
        .busy       (busy),
        .done       (done),
        .kp_count   (kp_count)
    );

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam real half_period  = 2.0;         // 4 ns clock
    localparam int  reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;                           // sync reset, held low
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;                          // released on an edge
    end

endmodule

// File: tb_kp_core.sv
`timescale 1ns/100ps

module tb_kp_core import kp_pkg::*; ();

    localparam int num_runs    = 5;
    localparam int cycle_limit = num_runs * (img_h * 14 * 4 + 100);   // whole-run budget

    logic      clk;
    logic      rst_n;
    logic      img_we;
    row_addr_t img_addr;
    row_t      img_data;
    logic      start;
    logic      filter_on;
    thresh_t   filter_threshold;
    logic      kp_ready;
    logic      kp_valid;
    keypoint_t kp_data;
    count_t    kp_count;
    logic      busy;
    logic      done;

    integer    seed;                            // $random state
    int        cycles;
    int        pix [img_h][img_w];              // current image
    int        dog [img_h][img_w];              // model difference image
    keypoint_t exp_q [$];                       // keypoints still expected
    int        exp_total;
    int        rx_count;                        // keypoints taken this run
    string     test_name;
    logic      ready_random;                    // back-pressure on/off
    logic      held_valid;                      // offer was stalled last edge
    keypoint_t held_data;

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    kp_core dut0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .img_we           (img_we),
        .img_addr         (img_addr),
        .img_data         (img_data),
        .start            (start),
        .filter_on        (filter_on),
        .filter_threshold (filter_threshold),
        .kp_ready         (kp_ready),
        .kp_valid         (kp_valid),
        .kp_data          (kp_data),
        .kp_count         (kp_count),
        .busy             (busy),
        .done             (done)
    );

    task halt_on_failure();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task check_value(input string what, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0h, actual %0h", what, expected, actual);
            halt_on_failure();
        end
    endtask

    function automatic int pix_at(int r, int c);
        if (r < 0 || r >= img_h || c < 0 || c >= img_w) begin
            return 0;                           // zero outside the image
        end
        return pix[r][c];
    endfunction

    // blur, difference image and expected keypoint list
    task build_model(input logic use_filter, input int thr);
        int        sum;
        int        d;
        int        wt;
        logic      is_max;
        logic      is_min;
        keypoint_t kp;
        exp_q.delete();
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                sum = 0;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        wt  = ((dr == 0) ? 2 : 1) * ((dc == 0) ? 2 : 1);   // 1-2-1 by 1-2-1
                        sum = sum + wt * pix_at(r + dr, c + dc);
                    end
                end
                dog[r][c] = pix[r][c] - sum / 16;   // truncated blur
            end
        end
        for (int r = 1; r < img_h - 1; r++) begin   // interior only in row-major order
            for (int c = 1; c < img_w - 1; c++) begin
                d      = dog[r][c];
                is_max = 1'b1;
                is_min = 1'b1;
                for (int dr = -1; dr <= 1; dr++) begin
                    for (int dc = -1; dc <= 1; dc++) begin
                        if (dr != 0 || dc != 0) begin
                            if (d <= dog[r+dr][c+dc]) is_max = 1'b0;
                            if (d >= dog[r+dr][c+dc]) is_min = 1'b0;
                        end
                    end
                end
                if ((is_max || is_min) && (!use_filter || ((d < 0) ? -d : d) > thr)) begin
                    kp.row   = row_addr_t'(r);
                    kp.col   = col_addr_t'(c);
                    kp.value = dog_t'(d);
                    exp_q.push_back(kp);
                end
            end
        end
        exp_total = exp_q.size();
    endtask

    task load_image();
        row_t line;
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                line[c] = pixel_t'(pix[r][c]);
            end
            @(posedge clk);
            img_we   <= 1'b1;
            img_addr <= row_addr_t'(r);
            img_data <= line;
        end
        @(posedge clk);
        img_we <= 1'b0;
    endtask

    task run_test(input string name, input logic flat, input logic use_filter,
                  input int thr, input logic stall_ready, input logic first);
        int level;
        test_name = name;
        level     = $random(seed) & 8'hff;      // flat image grey level
        for (int r = 0; r < img_h; r++) begin
            for (int c = 0; c < img_w; c++) begin
                pix[r][c] = flat ? level : ($random(seed) & 8'hff);
            end
        end
        build_model(use_filter, thr);
        rx_count = 0;
        if (!first) begin
            @(negedge clk);
            check_value({name, " busy between runs"}, 0, busy);
            check_value({name, " done between runs"}, 1, done);
        end
        ready_random = stall_ready;
        load_image();
        @(posedge clk);
        filter_on        <= use_filter;
        filter_threshold <= thresh_t'(thr);
        start            <= 1'b1;
        @(posedge clk);
        start <= 1'b0;                          // sampled on this edge
        @(negedge clk);
        check_value({name, " busy after start"}, 1, busy);
        check_value({name, " done after start"}, 0, done);
        do begin
            @(negedge clk);
        end while (!done);                      // wait for the finished phase
        ready_random = 1'b0;
        check_value({name, " keypoints left"}, 0, exp_q.size());
        check_value({name, " keypoints taken"}, exp_total, rx_count);
        check_value({name, " kp_count"}, exp_total, kp_count);
        check_value({name, " busy at done"}, 0, busy);
        if (flat) begin
            check_value({name, " kp_count of flat image"}, 0, kp_count);
        end
    endtask

    // stream monitor on values settled before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (held_valid) begin
                check_value({test_name, " kp_valid while stalled"}, 1, kp_valid);
                check_value({test_name, " kp_data while stalled"}, held_data, kp_data);
            end
            if (kp_valid && kp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("%s: DUT sent a keypoint the model does not expect", test_name);
                    halt_on_failure();
                end else begin
                    check_value($sformatf("%s keypoint %0d", test_name, rx_count),
                                exp_q[0], kp_data);
                    void'(exp_q.pop_front());
                    rx_count = rx_count + 1;
                end
            end
            held_valid = kp_valid && !kp_ready;
            held_data  = kp_data;
        end
    end

    always @(posedge clk) begin
        if (ready_random) begin
            kp_ready <= ($random(seed) & 1) != 0;   // roughly half the edges
        end else begin
            kp_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            halt_on_failure();
        end
    end

    initial begin
        int thr;
        seed             = 16;
        cycles           = 0;
        img_we           = 1'b0;
        img_addr         = '0;
        img_data         = '0;
        start            = 1'b0;
        filter_on        = 1'b0;
        filter_threshold = '0;
        kp_ready         = 1'b1;
        ready_random     = 1'b0;
        held_valid       = 1'b0;
        held_data        = '0;
        rx_count         = 0;
        exp_total        = 0;
        test_name        = "reset";
        wait (rst_n);
        @(negedge clk);
        check_value("reset kp_valid", 0, kp_valid);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        check_value("reset kp_count", 0, kp_count);
        run_test("random_nofilter", 1'b0, 1'b0, 0, 1'b0, 1'b1);
        thr = ($random(seed) & 32'h7fff_ffff) % 41;     // small enough to leave hits
        run_test("random_filter", 1'b0, 1'b1, thr, 1'b0, 1'b0);
        run_test("random_backpressure", 1'b0, 1'b0, 0, 1'b1, 1'b0);
        run_test("flat_image", 1'b1, 1'b0, 0, 1'b0, 1'b0);
        thr = ($random(seed) & 32'h7fff_ffff) % 41;
        run_test("restart_filter_backpressure", 1'b0, 1'b1, thr, 1'b1, 1'b0);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sources.f
kp_pkg.sv
kp_row_mem.sv
kp_line_buffer.sv
kp_gauss_row.sv
kp_dog_extrema.sv
kp_scan_counter.sv
kp_phase_fsm.sv
kp_core.sv
tb_clock_gen.sv
tb_kp_core.sv
